// ==== cpu_pkg.sv ====
// widths, reset pc, bus response code, opcode, alu and branch enums
package cpu_pkg;

  localparam int XLEN   = 64;
  localparam int ILEN   = 32;
  localparam int RIDX_W = 5;

  localparam logic [XLEN-1:0] RESET_PC  = 64'h8000_0000;
  localparam logic [1:0]      RESP_OKAY = 2'b00;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS    // op2 straight through, lui
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_JUMP
  } br_op_e;

endpackage

// ==== regfile.sv ====
// integer register file, two combinational reads, one write, x0 fixed to zero
`timescale 1ns/1ps

module regfile (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic [cpu_pkg::RIDX_W-1:0] i_rs1,
  input  logic [cpu_pkg::RIDX_W-1:0] i_rs2,
  input  logic [cpu_pkg::RIDX_W-1:0] i_rd,
  input  logic                       i_rd_wen,
  input  logic [cpu_pkg::XLEN-1:0]   i_rd_wdata,
  output logic [cpu_pkg::XLEN-1:0]   o_rs1_data,
  output logic [cpu_pkg::XLEN-1:0]   o_rs2_data
);

  logic [cpu_pkg::XLEN-1:0] regs [2**cpu_pkg::RIDX_W];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 2**cpu_pkg::RIDX_W; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_wdata;
    end
  end

  // a write in this cycle is seen on the read ports next cycle
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== if_stage.sv ====
// fetch stage: pc, fetch bus request, one-entry instruction buffer, redirect discard
`timescale 1ns/1ps

module if_stage (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_if_ready,
  input  logic [cpu_pkg::XLEN-1:0] i_if_rdata,
  input  logic [1:0]               i_if_resp,
  input  logic                     i_fetched_ack,
  input  logic                     i_ex_redirect,
  input  logic [cpu_pkg::XLEN-1:0] i_ex_target,
  output logic                     o_if_valid,
  output logic [cpu_pkg::XLEN-1:0] o_if_addr,
  output logic                     o_fetched_req,
  output logic [cpu_pkg::XLEN-1:0] o_if_pc,
  output logic [cpu_pkg::ILEN-1:0] o_if_inst
);

  logic [cpu_pkg::XLEN-1:0] pc_q;
  logic [cpu_pkg::XLEN-1:0] pc_n;
  logic                     discard_q;
  logic                     pending;
  logic                     good;
  logic                     full_n;

  assign pending = o_if_valid & ~i_if_ready;

  // word is kept only if okay and not overtaken by a redirect
  assign good = o_if_valid & i_if_ready & (i_if_resp == cpu_pkg::RESP_OKAY) &
                ~discard_q & ~i_ex_redirect;

  always_comb begin
    if (i_ex_redirect) begin
      pc_n = i_ex_target;
    end else if (good) begin
      pc_n = o_if_addr + 64'd4;
    end else begin
      pc_n = pc_q;
    end
  end

  // the buffer fills only from our own response, so it is empty while a request is out
  assign full_n = i_ex_redirect ? 1'b0 :
                  good          ? 1'b1 : (o_fetched_req & ~i_fetched_ack);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q          <= cpu_pkg::RESET_PC;
      o_if_valid    <= 1'b0;
      o_fetched_req <= 1'b0;
      discard_q     <= 1'b0;
    end else begin
      pc_q          <= pc_n;
      o_fetched_req <= full_n;
      if (pending) begin
        // redirect while waiting, drop whatever comes back
        discard_q <= discard_q | i_ex_redirect;
      end else begin
        o_if_valid <= ~full_n;
        discard_q  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!pending) begin
      o_if_addr <= pc_n;
    end
    if (good) begin
      o_if_pc   <= o_if_addr;
      o_if_inst <= o_if_addr[2] ? i_if_rdata[63:32] : i_if_rdata[31:0];
    end
  end

  a_addr_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    pending |=> (o_if_valid && $stable(o_if_addr)));

endmodule

// ==== id_stage.sv ====
// decode stage: decoder, immediates, operand select, register hazard stall
`timescale 1ns/1ps

module id_stage (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_fetched_req,
  input  logic [cpu_pkg::XLEN-1:0]   i_pc,
  input  logic [cpu_pkg::ILEN-1:0]   i_inst,
  input  logic [cpu_pkg::XLEN-1:0]   i_rs1_data,
  input  logic [cpu_pkg::XLEN-1:0]   i_rs2_data,
  input  logic                       i_decoded_ack,
  input  logic                       i_ex_redirect,
  input  logic [cpu_pkg::RIDX_W-1:0] i_ex_rd,
  input  logic                       i_ex_rd_wen,
  input  logic [cpu_pkg::RIDX_W-1:0] i_wb_rd,
  input  logic                       i_wb_rd_wen,
  output logic                       o_fetched_ack,
  output logic [cpu_pkg::RIDX_W-1:0] o_rs1,
  output logic [cpu_pkg::RIDX_W-1:0] o_rs2,
  output logic                       o_decoded_req,
  output logic [cpu_pkg::XLEN-1:0]   o_pc,
  output cpu_pkg::alu_op_e           o_alu_op,
  output cpu_pkg::br_op_e            o_br_op,
  output logic [cpu_pkg::XLEN-1:0]   o_op1,
  output logic [cpu_pkg::XLEN-1:0]   o_op2,
  output logic [cpu_pkg::XLEN-1:0]   o_cmp_a,
  output logic [cpu_pkg::XLEN-1:0]   o_cmp_b,
  output logic [cpu_pkg::XLEN-1:0]   o_imm,
  output logic [cpu_pkg::RIDX_W-1:0] o_rd,
  output logic                       o_rd_wen
);

  logic                     full_q;
  logic [cpu_pkg::ILEN-1:0] inst_q;
  logic [cpu_pkg::XLEN-1:0] imm_i;
  logic [cpu_pkg::XLEN-1:0] imm_u;
  logic [cpu_pkg::XLEN-1:0] imm_b;
  logic [cpu_pkg::XLEN-1:0] imm_j;
  logic [9:0]               funct;
  logic                     rs1_used;
  logic                     rs2_used;
  logic                     rs1_hit;
  logic                     rs2_hit;

  assign o_rs1   = inst_q[19:15];
  assign o_rs2   = inst_q[24:20];
  assign o_rd    = inst_q[11:7];
  assign o_cmp_a = i_rs1_data;
  assign o_cmp_b = i_rs2_data;
  assign funct   = {inst_q[31:25], inst_q[14:12]};

  assign imm_i = {{52{inst_q[31]}}, inst_q[31:20]};
  assign imm_u = {{32{inst_q[31]}}, inst_q[31:12], 12'b0};
  assign imm_b = {{51{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_j = {{43{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21],
                  1'b0};

  always_comb begin
    o_alu_op = cpu_pkg::ALU_ADD;
    o_br_op  = cpu_pkg::BR_NONE;
    o_op1    = i_rs1_data;
    o_op2    = i_rs2_data;
    o_imm    = imm_i;
    o_rd_wen = 1'b0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    case (inst_q[6:0])
      cpu_pkg::OP_LUI: begin
        o_alu_op = cpu_pkg::ALU_PASS;
        o_op2    = imm_u;
        o_imm    = imm_u;
        o_rd_wen = 1'b1;
      end
      cpu_pkg::OP_IMM: begin
        rs1_used = 1'b1;
        o_op2    = imm_i;
        o_rd_wen = (funct[2:0] == 3'b000);   // addi only
      end
      cpu_pkg::OP_REG: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        o_rd_wen = 1'b1;
        case (funct)
          10'b0000000_000: o_alu_op = cpu_pkg::ALU_ADD;
          10'b0100000_000: o_alu_op = cpu_pkg::ALU_SUB;
          10'b0000000_100: o_alu_op = cpu_pkg::ALU_XOR;
          10'b0000000_110: o_alu_op = cpu_pkg::ALU_OR;
          10'b0000000_111: o_alu_op = cpu_pkg::ALU_AND;
          default:         o_rd_wen = 1'b0;
        endcase
      end
      cpu_pkg::OP_BRANCH: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        o_imm    = imm_b;
        if (funct[2:0] == 3'b000) begin
          o_br_op = cpu_pkg::BR_EQ;
        end else if (funct[2:0] == 3'b001) begin
          o_br_op = cpu_pkg::BR_NE;
        end
      end
      cpu_pkg::OP_JAL: begin
        // link value pc+4 comes out of the alu
        o_br_op  = cpu_pkg::BR_JUMP;
        o_op1    = o_pc;
        o_op2    = 64'd4;
        o_imm    = imm_j;
        o_rd_wen = 1'b1;
      end
      default: o_rd_wen = 1'b0;
    endcase
  end

  // no forwarding, wait until ex and wb no longer hold a writer of rs1/rs2
  assign rs1_hit = rs1_used && (o_rs1 != '0) &&
                   ((i_ex_rd_wen && (i_ex_rd == o_rs1)) || (i_wb_rd_wen && (i_wb_rd == o_rs1)));
  assign rs2_hit = rs2_used && (o_rs2 != '0) &&
                   ((i_ex_rd_wen && (i_ex_rd == o_rs2)) || (i_wb_rd_wen && (i_wb_rd == o_rs2)));

  assign o_decoded_req = full_q & ~rs1_hit & ~rs2_hit;
  assign o_fetched_ack = ~full_q | (o_decoded_req & i_decoded_ack);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full_q <= 1'b0;
    end else if (i_ex_redirect) begin
      full_q <= 1'b0;
    end else if (i_fetched_req && o_fetched_ack) begin
      full_q <= 1'b1;
    end else if (o_decoded_req && i_decoded_ack) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched_req && o_fetched_ack) begin
      o_pc   <= i_pc;
      inst_q <= i_inst;
    end
  end

endmodule

// ==== exe_stage.sv ====
// execute stage: alu, branch compare, redirect pulse, result register
`timescale 1ns/1ps

module exe_stage (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_decoded_req,
  input  logic [cpu_pkg::XLEN-1:0]   i_pc,
  input  cpu_pkg::alu_op_e           i_alu_op,
  input  cpu_pkg::br_op_e            i_br_op,
  input  logic [cpu_pkg::XLEN-1:0]   i_op1,
  input  logic [cpu_pkg::XLEN-1:0]   i_op2,
  input  logic [cpu_pkg::XLEN-1:0]   i_cmp_a,
  input  logic [cpu_pkg::XLEN-1:0]   i_cmp_b,
  input  logic [cpu_pkg::XLEN-1:0]   i_imm,
  input  logic [cpu_pkg::RIDX_W-1:0] i_rd,
  input  logic                       i_rd_wen,
  input  logic                       i_executed_ack,
  output logic                       o_decoded_ack,
  output logic                       o_executed_req,
  output logic [cpu_pkg::XLEN-1:0]   o_pc,
  output logic [cpu_pkg::RIDX_W-1:0] o_rd,
  output logic                       o_rd_wen,
  output logic [cpu_pkg::XLEN-1:0]   o_rd_wdata,
  output logic                       o_ex_redirect,
  output logic [cpu_pkg::XLEN-1:0]   o_ex_target
);

  logic                     full_q;
  logic                     rd_wen_q;
  logic                     accept;
  logic                     taken;
  logic [cpu_pkg::XLEN-1:0] alu_res;

  assign o_decoded_ack  = ~full_q | i_executed_ack;
  assign accept         = i_decoded_req & o_decoded_ack;
  assign o_executed_req = full_q;
  // qualified, also serves as the hazard write flag
  assign o_rd_wen       = full_q & rd_wen_q;

  always_comb begin
    case (i_alu_op)
      cpu_pkg::ALU_SUB:  alu_res = i_op1 - i_op2;
      cpu_pkg::ALU_AND:  alu_res = i_op1 & i_op2;
      cpu_pkg::ALU_OR:   alu_res = i_op1 | i_op2;
      cpu_pkg::ALU_XOR:  alu_res = i_op1 ^ i_op2;
      cpu_pkg::ALU_PASS: alu_res = i_op2;
      default:           alu_res = i_op1 + i_op2;
    endcase
  end

  always_comb begin
    case (i_br_op)
      cpu_pkg::BR_EQ:   taken = (i_cmp_a == i_cmp_b);
      cpu_pkg::BR_NE:   taken = (i_cmp_a != i_cmp_b);
      cpu_pkg::BR_JUMP: taken = 1'b1;
      default:          taken = 1'b0;
    endcase
  end

  // one pulse, in the accept cycle
  assign o_ex_redirect = accept & taken;
  assign o_ex_target   = i_pc + i_imm;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full_q <= 1'b0;
    end else begin
      full_q <= accept | (full_q & ~i_executed_ack);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_pc       <= i_pc;
      o_rd       <= i_rd;
      rd_wen_q   <= i_rd_wen;
      o_rd_wdata <= alu_res;
    end
  end

  // decode is emptied by the redirect, so nothing can be accepted next cycle
  a_redirect_single: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_ex_redirect |=> !o_ex_redirect);

endmodule

// ==== wb_stage.sv ====
// writeback stage: final register, regfile write, commit port
`timescale 1ns/1ps

module wb_stage (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_executed_req,
  input  logic [cpu_pkg::XLEN-1:0]   i_pc,
  input  logic [cpu_pkg::RIDX_W-1:0] i_rd,
  input  logic                       i_rd_wen,
  input  logic [cpu_pkg::XLEN-1:0]   i_rd_wdata,
  output logic                       o_executed_ack,
  output logic                       o_rf_wen,
  output logic [cpu_pkg::RIDX_W-1:0] o_rf_rd,
  output logic [cpu_pkg::XLEN-1:0]   o_rf_wdata,
  output logic                       o_cmt_valid,
  output logic [cpu_pkg::XLEN-1:0]   o_cmt_pc,
  output logic [cpu_pkg::RIDX_W-1:0] o_cmt_rd,
  output logic                       o_cmt_wen,
  output logic [cpu_pkg::XLEN-1:0]   o_cmt_wdata
);

  logic wen_q;

  // commit never back-pressures
  assign o_executed_ack = 1'b1;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cmt_valid <= 1'b0;
    end else begin
      o_cmt_valid <= i_executed_req;
    end
  end

  always_ff @(posedge clk) begin
    if (i_executed_req) begin
      o_cmt_pc    <= i_pc;
      o_cmt_rd    <= i_rd;
      wen_q       <= i_rd_wen;
      o_cmt_wdata <= i_rd_wdata;
    end
  end

  assign o_cmt_wen  = o_cmt_valid & wen_q;
  assign o_rf_wen   = o_cmt_wen;
  assign o_rf_rd    = o_cmt_rd;
  assign o_rf_wdata = o_cmt_wdata;

endmodule

// ==== cpu.sv ====
// top level: four pipeline stages and the register file
`timescale 1ns/1ps

module cpu (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_if_ready,
  input  logic [cpu_pkg::XLEN-1:0]   i_if_rdata,
  input  logic [1:0]                 i_if_resp,
  output logic                       o_if_valid,
  output logic [cpu_pkg::XLEN-1:0]   o_if_addr,
  output logic                       o_cmt_valid,
  output logic [cpu_pkg::XLEN-1:0]   o_cmt_pc,
  output logic [cpu_pkg::RIDX_W-1:0] o_cmt_rd,
  output logic                       o_cmt_wen,
  output logic [cpu_pkg::XLEN-1:0]   o_cmt_wdata
);

  // stage handshakes
  logic                       fetched_req;
  logic                       fetched_ack;
  logic                       decoded_req;
  logic                       decoded_ack;
  logic                       executed_req;
  logic                       executed_ack;

  // if -> id
  logic [cpu_pkg::XLEN-1:0]   if_pc;
  logic [cpu_pkg::ILEN-1:0]   if_inst;

  // id <-> regfile, id -> ex
  logic [cpu_pkg::RIDX_W-1:0] id_rs1;
  logic [cpu_pkg::RIDX_W-1:0] id_rs2;
  logic [cpu_pkg::XLEN-1:0]   rs1_data;
  logic [cpu_pkg::XLEN-1:0]   rs2_data;
  logic [cpu_pkg::XLEN-1:0]   id_pc;
  cpu_pkg::alu_op_e           id_alu_op;
  cpu_pkg::br_op_e            id_br_op;
  logic [cpu_pkg::XLEN-1:0]   id_op1;
  logic [cpu_pkg::XLEN-1:0]   id_op2;
  logic [cpu_pkg::XLEN-1:0]   id_cmp_a;
  logic [cpu_pkg::XLEN-1:0]   id_cmp_b;
  logic [cpu_pkg::XLEN-1:0]   id_imm;
  logic [cpu_pkg::RIDX_W-1:0] id_rd;
  logic                       id_rd_wen;

  // ex -> wb, redirect
  logic [cpu_pkg::XLEN-1:0]   ex_pc;
  logic [cpu_pkg::RIDX_W-1:0] ex_rd;
  logic                       ex_rd_wen;
  logic [cpu_pkg::XLEN-1:0]   ex_rd_wdata;
  logic                       ex_redirect;
  logic [cpu_pkg::XLEN-1:0]   ex_target;

  // wb -> regfile
  logic                       rf_wen;
  logic [cpu_pkg::RIDX_W-1:0] rf_rd;
  logic [cpu_pkg::XLEN-1:0]   rf_wdata;

  if_stage if_stage0 (
    .clk           (clk),           .i_rst_n       (i_rst_n),
    .i_if_ready    (i_if_ready),    .i_if_rdata    (i_if_rdata),
    .i_if_resp     (i_if_resp),     .i_fetched_ack (fetched_ack),
    .i_ex_redirect (ex_redirect),   .i_ex_target   (ex_target),
    .o_if_valid    (o_if_valid),    .o_if_addr     (o_if_addr),
    .o_fetched_req (fetched_req),   .o_if_pc       (if_pc),
    .o_if_inst     (if_inst)
  );

  id_stage id_stage0 (
    .clk           (clk),           .i_rst_n       (i_rst_n),
    .i_fetched_req (fetched_req),   .i_pc          (if_pc),
    .i_inst        (if_inst),       .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),      .i_decoded_ack (decoded_ack),
    .i_ex_redirect (ex_redirect),   .i_ex_rd       (ex_rd),
    .i_ex_rd_wen   (ex_rd_wen),     .i_wb_rd       (rf_rd),
    .i_wb_rd_wen   (rf_wen),        .o_fetched_ack (fetched_ack),
    .o_rs1         (id_rs1),        .o_rs2         (id_rs2),
    .o_decoded_req (decoded_req),   .o_pc          (id_pc),
    .o_alu_op      (id_alu_op),     .o_br_op       (id_br_op),
    .o_op1         (id_op1),        .o_op2         (id_op2),
    .o_cmp_a       (id_cmp_a),      .o_cmp_b       (id_cmp_b),
    .o_imm         (id_imm),        .o_rd          (id_rd),
    .o_rd_wen      (id_rd_wen)
  );

  exe_stage exe_stage0 (
    .clk            (clk),          .i_rst_n        (i_rst_n),
    .i_decoded_req  (decoded_req),  .i_pc           (id_pc),
    .i_alu_op       (id_alu_op),    .i_br_op        (id_br_op),
    .i_op1          (id_op1),       .i_op2          (id_op2),
    .i_cmp_a        (id_cmp_a),     .i_cmp_b        (id_cmp_b),
    .i_imm          (id_imm),       .i_rd           (id_rd),
    .i_rd_wen       (id_rd_wen),    .i_executed_ack (executed_ack),
    .o_decoded_ack  (decoded_ack),  .o_executed_req (executed_req),
    .o_pc           (ex_pc),        .o_rd           (ex_rd),
    .o_rd_wen       (ex_rd_wen),    .o_rd_wdata     (ex_rd_wdata),
    .o_ex_redirect  (ex_redirect),  .o_ex_target    (ex_target)
  );

  wb_stage wb_stage0 (
    .clk            (clk),          .i_rst_n        (i_rst_n),
    .i_executed_req (executed_req), .i_pc           (ex_pc),
    .i_rd           (ex_rd),        .i_rd_wen       (ex_rd_wen),
    .i_rd_wdata     (ex_rd_wdata),  .o_executed_ack (executed_ack),
    .o_rf_wen       (rf_wen),       .o_rf_rd        (rf_rd),
    .o_rf_wdata     (rf_wdata),     .o_cmt_valid    (o_cmt_valid),
    .o_cmt_pc       (o_cmt_pc),     .o_cmt_rd       (o_cmt_rd),
    .o_cmt_wen      (o_cmt_wen),    .o_cmt_wdata    (o_cmt_wdata)
  );

  regfile regfile0 (
    .clk            (clk),          .i_rst_n        (i_rst_n),
    .i_rs1          (id_rs1),       .i_rs2          (id_rs2),
    .i_rd           (rf_rd),        .i_rd_wen       (rf_wen),
    .i_rd_wdata     (rf_wdata),     .o_rs1_data     (rs1_data),
    .o_rs2_data     (rs2_data)
  );

endmodule

// ==== tb_cpu.sv ====
// program memory, fetch bus responder, reference model, commit assertions and watchdog for cpu
`timescale 1ns/1ps

module tb_cpu;

  logic                       clk;
  logic                       rst_n;
  logic                       if_ready;
  logic [cpu_pkg::XLEN-1:0]   if_rdata;
  logic [1:0]                 if_resp;
  logic                       if_valid;
  logic [cpu_pkg::XLEN-1:0]   if_addr;
  logic                       cmt_valid;
  logic [cpu_pkg::XLEN-1:0]   cmt_pc;
  logic [cpu_pkg::RIDX_W-1:0] cmt_rd;
  logic                       cmt_wen;
  logic [cpu_pkg::XLEN-1:0]   cmt_wdata;

  // program memory of 64-bit words
  logic [63:0] imem [0:31];
  int          prog_len;
  int          loop_cnt;
  integer      seed;
  int          nfetch;
  logic        fetch_seen;

  // expected commit queue whose head advances on each commit
  logic [63:0] exp_pc    [0:255];
  logic [4:0]  exp_rd    [0:255];
  logic        exp_wen   [0:255];
  logic [63:0] exp_wdata [0:255];
  int          head;
  int          tail;
  logic [63:0] h_pc;
  logic [4:0]  h_rd;
  logic        h_wen;
  logic [63:0] h_wdata;

  assign h_pc    = exp_pc[head];
  assign h_rd    = exp_rd[head];
  assign h_wen   = exp_wen[head];
  assign h_wdata = exp_wdata[head];

  cpu dut0 (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_if_ready  (if_ready),
    .i_if_rdata  (if_rdata),
    .i_if_resp   (if_resp),
    .o_if_valid  (if_valid),
    .o_if_addr   (if_addr),
    .o_cmt_valid (cmt_valid),
    .o_cmt_pc    (cmt_pc),
    .o_cmt_rd    (cmt_rd),
    .o_cmt_wen   (cmt_wen),
    .o_cmt_wdata (cmt_wdata)
  );

  function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, cpu_pkg::OP_LUI};
  endfunction

  function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, cpu_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] rtype_inst(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::OP_JAL};
  endfunction

  function automatic logic [63:0] read_dword(input logic [63:0] addr);
    logic [63:0] off;
    off = addr - cpu_pkg::RESET_PC;
    if (off < 64'd256) begin
      return imem[off[7:3]];
    end
    return 64'd0;
  endfunction

  task automatic put(input logic [31:0] inst);
    if (prog_len[0]) begin
      imem[prog_len >> 1][63:32] = inst;
    end else begin
      imem[prog_len >> 1][31:0] = inst;
    end
    prog_len++;
  endtask

  task automatic load_program();
    for (int i = 0; i < 32; i++) begin
      imem[i] = 64'd0;
    end
    put(lui_inst(5'd1, 20'h80001));
    put(addi_inst(5'd2, 5'd0, loop_cnt[11:0]));
    put(addi_inst(5'd3, 5'd0, 12'hfff));
    // loop top starts a dependent chain of alu ops
    put(rtype_inst(7'h00, 3'b000, 5'd4, 5'd1, 5'd3));
    put(rtype_inst(7'h20, 3'b000, 5'd5, 5'd4, 5'd1));
    put(rtype_inst(7'h00, 3'b111, 5'd6, 5'd5, 5'd1));
    put(rtype_inst(7'h00, 3'b110, 5'd7, 5'd6, 5'd4));
    put(rtype_inst(7'h00, 3'b100, 5'd8, 5'd7, 5'd1));
    put(addi_inst(5'd0, 5'd8, 12'd5));
    put(rtype_inst(7'h00, 3'b000, 5'd9, 5'd0, 5'd8));
    put(addi_inst(5'd1, 5'd1, 12'h111));
    // skips the decrement on passes where x9 is zero
    put(branch_inst(3'b000, 5'd0, 5'd9, 13'd8));
    put(addi_inst(5'd2, 5'd2, 12'hfff));
    // back to loop top at -40
    put(branch_inst(3'b001, 5'd2, 5'd0, 13'h1fd8));
    put(branch_inst(3'b000, 5'd2, 5'd0, 13'd8));
    put(addi_inst(5'd10, 5'd0, 12'd99));
    put(jal_inst(5'd11, 21'd8));
    put(addi_inst(5'd12, 5'd0, 12'd77));
    // park here
    put(jal_inst(5'd0, 21'd0));
  endtask

  // architectural model that runs until the self jump
  task automatic run_model();
    logic [63:0] x [32];
    logic [63:0] pc;
    logic [63:0] next;
    logic [63:0] dw;
    logic [31:0] in;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic        wr;
    logic        done;
    for (int i = 0; i < 32; i++) begin
      x[i] = 64'd0;
    end
    pc   = cpu_pkg::RESET_PC;
    done = 1'b0;
    tail = 0;
    for (int step = 0; step < 200 && !done; step++) begin
      dw   = read_dword(pc);
      in   = pc[2] ? dw[63:32] : dw[31:0];
      a    = x[in[19:15]];
      b    = x[in[24:20]];
      next = pc + 64'd4;
      wr   = 1'b1;
      res  = 64'd0;
      case (in[6:0])
        cpu_pkg::OP_LUI: res = {{32{in[31]}}, in[31:12], 12'h0};
        cpu_pkg::OP_IMM: res = a + {{52{in[31]}}, in[31:20]};
        cpu_pkg::OP_REG: begin
          case ({in[30], in[14:12]})
            4'b1000: res = a - b;
            4'b0111: res = a & b;
            4'b0110: res = a | b;
            4'b0100: res = a ^ b;
            default: res = a + b;
          endcase
        end
        cpu_pkg::OP_BRANCH: begin
          wr = 1'b0;
          if (in[12] ? (a != b) : (a == b)) begin
            next = pc + {{52{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
          end
        end
        default: begin
          res  = pc + 64'd4;
          next = pc + {{44{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
        end
      endcase
      exp_pc[tail]    = pc;
      exp_rd[tail]    = in[11:7];
      exp_wen[tail]   = wr;
      exp_wdata[tail] = res;
      tail++;
      if (wr && in[11:7] != 5'd0) begin
        x[in[11:7]] = res;
      end
      done = (next == pc);
      pc   = next;
    end
  endtask

  task automatic stop_failed();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic value_error(input string sig, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    $display("Error: %s expected 0x%h actual 0x%h", sig, exp_v, act_v);
    stop_failed();
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fetch bus responder where every sixth accepted fetch gets a bus error
  always @(posedge clk) begin
    #1;
    if_ready = (($random(seed) & 3) != 0);
    if (if_valid && if_ready) begin
      nfetch++;
      if (nfetch % 6 == 4) begin
        // junk that writes x31 if it ever retires
        if_rdata = {2{addi_inst(5'd31, 5'd0, 12'h7ff)}};
        if_resp  = 2'b10;
      end else begin
        if_rdata = read_dword(if_addr);
        if_resp  = cpu_pkg::RESP_OKAY;
      end
    end else begin
      if_rdata = 64'd0;
      if_resp  = cpu_pkg::RESP_OKAY;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head       <= 0;
      fetch_seen <= 1'b0;
    end else begin
      if (cmt_valid) begin
        head <= head + 1;
      end
      if (if_valid) begin
        fetch_seen <= 1'b1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!if_valid && !cmt_valid))
    else begin
      $display("fetch or commit active while reset is asserted");
      stop_failed();
    end

  a_first_cycle: assert property (@(posedge clk)
    $rose(rst_n) |-> (!if_valid && !cmt_valid) ##1 if_valid)
    else begin
      $display("fetch request missing or commit active just after reset");
      stop_failed();
    end

  a_first_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    (if_valid && !fetch_seen) |-> (if_addr == cpu_pkg::RESET_PC))
    else value_error("o_if_addr", cpu_pkg::RESET_PC, $sampled(if_addr));

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (if_valid && !if_ready) |=> (if_valid && $stable(if_addr)))
    else begin
      $display("fetch request dropped or changed its address before ready");
      stop_failed();
    end

  a_cmt_known: assert property (@(posedge clk) disable iff (!rst_n) cmt_valid |-> (head < tail))
    else begin
      $display("commit seen after the last expected instruction");
      stop_failed();
    end

  a_cmt_pc: assert property (@(posedge clk) disable iff (!rst_n) cmt_valid |-> (cmt_pc == h_pc))
    else value_error("o_cmt_pc", $sampled(h_pc), $sampled(cmt_pc));

  a_cmt_wen: assert property (@(posedge clk) disable iff (!rst_n)
    cmt_valid |-> (cmt_wen == h_wen))
    else value_error("o_cmt_wen", 64'($sampled(h_wen)), 64'($sampled(cmt_wen)));

  a_cmt_rd: assert property (@(posedge clk) disable iff (!rst_n)
    (cmt_valid && h_wen) |-> (cmt_rd == h_rd))
    else value_error("o_cmt_rd", 64'($sampled(h_rd)), 64'($sampled(cmt_rd)));

  a_cmt_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    (cmt_valid && h_wen) |-> (cmt_wdata == h_wdata))
    else value_error("o_cmt_wdata", $sampled(h_wdata), $sampled(cmt_wdata));

  // budget of 40 cycles per instruction per loop pass
  initial begin
    wait (prog_len != 0);
    repeat (40 * prog_len * loop_cnt + 10) @(posedge clk);
    $display("commits stopped before the end of the program");
    stop_failed();
  end

  initial begin
    if_ready = 1'b0;
    if_rdata = 64'd0;
    if_resp  = cpu_pkg::RESP_OKAY;
    rst_n    = 1'b1;
    seed     = 32'hd667_cdab;
    nfetch   = 0;
    prog_len = 0;
    loop_cnt = 3;
    load_program();
    run_model();
    #1 rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    wait (head == tail);
    #1;
    $display("test passed");
    $finish;
  end

endmodule

// ==== files.f ====
cpu_pkg.sv
regfile.sv
if_stage.sv
id_stage.sv
exe_stage.sv
wb_stage.sv
cpu.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - regfile.sv
  - if_stage.sv
  - id_stage.sv
  - exe_stage.sv
  - wb_stage.sv
  - cpu.sv
  - target: test
    files:
      - tb_cpu.sv
